/* src/periph_params.svh */
// Address map and register offsets of the peripheral subsystem
// Offsets are byte offsets within a 64-byte register window per peripheral
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

// Peripheral select field of the bus address
`define PERIPH_SEL_BIT_HI 13
`define PERIPH_SEL_BIT_LO 12

`define PERIPH_BASE_PLIC  32'h0000_0000
`define PERIPH_BASE_GPIO  32'h0000_1000
`define PERIPH_BASE_TIMER 32'h0000_2000

`define PLIC_PENDING 6'h00
`define PLIC_ENABLE  6'h04
`define PLIC_CLAIM   6'h08
`define PLIC_MSIP    6'h0C

`define GPIO_OUT         6'h00
`define GPIO_DIR         6'h04
`define GPIO_IN          6'h08
`define GPIO_INTR_EN     6'h0C
`define GPIO_INTR_STATUS 6'h10

`define TIMER_CTRL    6'h00
`define TIMER_COUNT   6'h04
`define TIMER_COMPARE 6'h08

// Source 0 is reserved and reads as no interrupt
`define PLIC_NUM_SRC       16
`define GPIO_WIDTH         8
`define PERIPH_NUM_EXT_INT 4

`define PLIC_SRC_GPIO  1
`define PLIC_SRC_TIMER 9
`define PLIC_SRC_EXT   10

`endif

/* src/periph_pkg.sv */
// Types shared by the register bus and the peripherals
`default_nettype none

package periph_pkg;

  typedef enum logic {
    REG_READ  = 1'b0,
    REG_WRITE = 1'b1
  } reg_op_e;

  typedef enum logic {
    BR_IDLE = 1'b0,
    BR_RESP = 1'b1
  } bridge_state_e;

  // Encoding follows the address select bits
  typedef enum logic [1:0] {
    SEL_PLIC  = 2'd0,
    SEL_GPIO  = 2'd1,
    SEL_TIMER = 2'd2,
    SEL_NONE  = 2'd3
  } periph_sel_e;

  // Byte-enable merge of a 32-bit register write
  function automatic logic [31:0] be_merge(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

endpackage

`default_nettype wire

/* src/obi_to_reg.sv */
// One access in flight; the response always comes one cycle after the grant
// Read data of writes is returned as zero
`timescale 1ns/100ps
`default_nettype none

module obi_to_reg (
  input  wire logic               clk_i,
  input  wire logic               rst_i,
  input  wire logic               req_i,
  input  wire logic               we_i,
  input  wire logic [31:0]        addr_i,
  input  wire logic [31:0]        wdata_i,
  input  wire logic [3:0]         be_i,
  output logic                    gnt_o,
  output logic                    rvalid_o,
  output logic [31:0]             rdata_o,
  output logic                    err_o,
  output logic                    reg_valid_o,
  output periph_pkg::reg_op_e     reg_op_o,
  output logic [31:0]             reg_addr_o,
  output logic [31:0]             reg_wdata_o,
  output logic [3:0]              reg_be_o,
  input  wire logic [31:0]        reg_rdata_i,
  input  wire logic               reg_err_i
);

  import periph_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;
  logic          grant;
  logic [31:0]   rsp_rdata_q;
  logic          rsp_err_q;

  assign gnt_o = (state_q == BR_IDLE);
  assign grant = req_i && gnt_o;

  // Strobe goes out in the grant cycle
  assign reg_valid_o = grant;
  assign reg_op_o    = we_i ? REG_WRITE : REG_READ;
  assign reg_addr_o  = addr_i;
  assign reg_wdata_o = wdata_i;
  assign reg_be_o    = be_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      BR_IDLE: if (grant) state_d = BR_RESP;
      BR_RESP: state_d = BR_IDLE;
      default: state_d = BR_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= BR_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant) begin
      rsp_rdata_q <= we_i ? 32'h0 : reg_rdata_i;
      rsp_err_q   <= reg_err_i;
    end
  end

  assign rvalid_o = (state_q == BR_RESP);
  assign rdata_o  = rsp_rdata_q;
  assign err_o    = rsp_err_q;

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_o |-> $past(req_i && gnt_o));

endmodule

`default_nettype wire

/* src/periph_reg_demux.sv */
// Only the select bits and the word offset are decoded, so the map aliases
// above bit 13; select value 3 answers with an error
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module periph_reg_demux (
  input  wire logic                reg_valid_i,
  input  periph_pkg::reg_op_e      reg_op_i,
  input  wire logic [31:0]         reg_addr_i,
  input  wire logic [31:0]         reg_wdata_i,
  input  wire logic [3:0]          reg_be_i,
  output logic [31:0]              reg_rdata_o,
  output logic                     reg_err_o,
  output logic                     plic_valid_o,
  output logic                     gpio_valid_o,
  output logic                     tmr_valid_o,
  output periph_pkg::reg_op_e      op_o,
  output logic [3:0]               offset_o,
  output logic [31:0]              wdata_o,
  output logic [3:0]               be_o,
  input  wire logic [31:0]         plic_rdata_i,
  input  wire logic [31:0]         gpio_rdata_i,
  input  wire logic [31:0]         tmr_rdata_i
);

  import periph_pkg::*;

  localparam logic [31:0] sel_mask = ((32'h1 << (`PERIPH_SEL_BIT_HI + 1)) - 32'h1) &
                                     ~((32'h1 << `PERIPH_SEL_BIT_LO) - 32'h1);

  logic [31:0] addr_base;
  periph_sel_e sel;

  assign addr_base = reg_addr_i & sel_mask;

  always_comb begin
    case (addr_base)
      `PERIPH_BASE_PLIC:  sel = SEL_PLIC;
      `PERIPH_BASE_GPIO:  sel = SEL_GPIO;
      `PERIPH_BASE_TIMER: sel = SEL_TIMER;
      default:            sel = SEL_NONE;
    endcase
  end

  assign plic_valid_o = reg_valid_i && (sel == SEL_PLIC);
  assign gpio_valid_o = reg_valid_i && (sel == SEL_GPIO);
  assign tmr_valid_o  = reg_valid_i && (sel == SEL_TIMER);

  assign op_o     = reg_op_i;
  assign offset_o = reg_addr_i[5:2];
  assign wdata_o  = reg_wdata_i;
  assign be_o     = reg_be_i;

  always_comb begin
    case (sel)
      SEL_PLIC:  reg_rdata_o = plic_rdata_i;
      SEL_GPIO:  reg_rdata_o = gpio_rdata_i;
      SEL_TIMER: reg_rdata_o = tmr_rdata_i;
      default:   reg_rdata_o = 32'h0;
    endcase
  end

  assign reg_err_o = (sel == SEL_NONE);

endmodule

`default_nettype wire

/* src/intr_ctrl.sv */
// Reduced PLIC with level sources and no priorities or threshold; lowest ID claims first
// A claim clears the pending bit; a source still high sets it again next cycle
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module intr_ctrl (
  input  wire logic                     clk_i,
  input  wire logic                     rst_i,
  input  wire logic                     valid_i,
  input  periph_pkg::reg_op_e           op_i,
  input  wire logic [3:0]               offset_i,
  input  wire logic [31:0]              wdata_i,
  input  wire logic [3:0]               be_i,
  input  wire logic [`PLIC_NUM_SRC-1:0] intr_src_i,
  output logic [31:0]                   rdata_o,
  output logic                          irq_o,
  output logic                          msip_o
);

  import periph_pkg::*;

  localparam int id_w = $clog2(`PLIC_NUM_SRC);

  logic [`PLIC_NUM_SRC-1:0] pending_q;
  logic [`PLIC_NUM_SRC-1:0] enable_q;
  logic                     msip_q;
  logic [`PLIC_NUM_SRC-1:0] pend_en;
  logic [`PLIC_NUM_SRC-1:0] claim_clr;
  logic [id_w-1:0]          claim_id;
  logic [5:0]               reg_off;
  logic                     wr;
  logic                     claim_rd;

  assign reg_off  = {offset_i, 2'b00};
  assign wr       = valid_i && (op_i == REG_WRITE);
  assign claim_rd = valid_i && (op_i == REG_READ) && (reg_off == `PLIC_CLAIM);
  assign pend_en  = pending_q & enable_q;

  // Scan downwards so the lowest ID is left at the end
  always_comb begin
    claim_id = '0;
    for (int i = `PLIC_NUM_SRC - 1; i > 0; i--) begin
      if (pend_en[i]) claim_id = id_w'(i);
    end
  end

  always_comb begin
    claim_clr = '0;
    if (claim_rd && (claim_id != '0)) claim_clr[claim_id] = 1'b1;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      pending_q <= '0;
      enable_q  <= '0;
      msip_q    <= 1'b0;
    end else begin
      pending_q    <= (pending_q | intr_src_i) & ~claim_clr;
      pending_q[0] <= 1'b0;
      if (wr && (reg_off == `PLIC_ENABLE)) begin
        for (int b = 0; b < `PLIC_NUM_SRC / 8; b++) begin
          if (be_i[b]) enable_q[8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
      if (wr && (reg_off == `PLIC_MSIP) && be_i[0]) msip_q <= wdata_i[0];
    end
  end

  always_comb begin
    case (reg_off)
      `PLIC_PENDING: rdata_o = 32'(pending_q);
      `PLIC_ENABLE:  rdata_o = 32'(enable_q);
      `PLIC_CLAIM:   rdata_o = 32'(claim_id);
      `PLIC_MSIP:    rdata_o = {31'h0, msip_q};
      default:       rdata_o = 32'h0;
    endcase
  end

  assign irq_o  = |pend_en;
  assign msip_o = msip_q;

  a_src0_not_driven: assert property (@(posedge clk_i) disable iff (rst_i)
    !intr_src_i[0]);

endmodule

`default_nettype wire

/* src/gpio_ctrl.sv */
// Inputs pass two sync flops; only rising edges raise interrupts
// Status bits are sticky and cleared by writing 1
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module gpio_ctrl (
  input  wire logic                   clk_i,
  input  wire logic                   rst_i,
  input  wire logic                   valid_i,
  input  periph_pkg::reg_op_e         op_i,
  input  wire logic [3:0]             offset_i,
  input  wire logic [31:0]            wdata_i,
  input  wire logic [3:0]             be_i,
  input  wire logic [`GPIO_WIDTH-1:0] gpio_i,
  output logic [31:0]                 rdata_o,
  output logic [`GPIO_WIDTH-1:0]      gpio_o,
  output logic [`GPIO_WIDTH-1:0]      gpio_en_o,
  output logic [`GPIO_WIDTH-1:0]      intr_o
);

  import periph_pkg::*;

  logic [`GPIO_WIDTH-1:0] out_q, dir_q, intr_en_q, status_q;
  logic [`GPIO_WIDTH-1:0] sync1_q, sync2_q, prev_q;
  logic [`GPIO_WIDTH-1:0] rise;
  logic [5:0]             reg_off;
  logic                   wr;

  assign reg_off = {offset_i, 2'b00};
  assign wr      = valid_i && (op_i == REG_WRITE) && be_i[0];
  assign rise    = sync2_q & ~prev_q;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
      out_q     <= '0;
      dir_q     <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
    end else begin
      sync1_q <= gpio_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
      if (wr && (reg_off == `GPIO_OUT))     out_q     <= wdata_i[`GPIO_WIDTH-1:0];
      if (wr && (reg_off == `GPIO_DIR))     dir_q     <= wdata_i[`GPIO_WIDTH-1:0];
      if (wr && (reg_off == `GPIO_INTR_EN)) intr_en_q <= wdata_i[`GPIO_WIDTH-1:0];
      // A new edge wins over a clear in the same cycle
      if (wr && (reg_off == `GPIO_INTR_STATUS)) begin
        status_q <= (status_q & ~wdata_i[`GPIO_WIDTH-1:0]) | (rise & intr_en_q);
      end else begin
        status_q <= status_q | (rise & intr_en_q);
      end
    end
  end

  always_comb begin
    case (reg_off)
      `GPIO_OUT:         rdata_o = 32'(out_q);
      `GPIO_DIR:         rdata_o = 32'(dir_q);
      `GPIO_IN:          rdata_o = 32'(sync2_q);
      `GPIO_INTR_EN:     rdata_o = 32'(intr_en_q);
      `GPIO_INTR_STATUS: rdata_o = 32'(status_q);
      default:           rdata_o = 32'h0;
    endcase
  end

  assign gpio_o    = out_q;
  assign gpio_en_o = dir_q;
  assign intr_o    = status_q;

endmodule

`default_nettype wire

/* src/event_timer.sv */
// 32-bit up counter; the interrupt is a level, not a pulse
// Counter wraps silently at the top
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module event_timer (
  input  wire logic          clk_i,
  input  wire logic          rst_i,
  input  wire logic          valid_i,
  input  periph_pkg::reg_op_e op_i,
  input  wire logic [3:0]    offset_i,
  input  wire logic [31:0]   wdata_i,
  input  wire logic [3:0]    be_i,
  output logic [31:0]        rdata_o,
  output logic               intr_o
);

  import periph_pkg::*;

  logic        en_q;
  logic [31:0] count_q;
  logic [31:0] compare_q;
  logic [5:0]  reg_off;
  logic        wr;

  assign reg_off = {offset_i, 2'b00};
  assign wr      = valid_i && (op_i == REG_WRITE);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q      <= 1'b0;
      count_q   <= 32'h0;
      compare_q <= 32'h0;
    end else begin
      if (wr && (reg_off == `TIMER_CTRL) && be_i[0]) en_q <= wdata_i[0];
      // Load takes priority over counting
      if (wr && (reg_off == `TIMER_COUNT)) begin
        count_q <= be_merge(count_q, wdata_i, be_i);
      end else if (en_q) begin
        count_q <= count_q + 32'h1;
      end
      if (wr && (reg_off == `TIMER_COMPARE)) compare_q <= be_merge(compare_q, wdata_i, be_i);
    end
  end

  always_comb begin
    case (reg_off)
      `TIMER_CTRL:    rdata_o = {31'h0, en_q};
      `TIMER_COUNT:   rdata_o = count_q;
      `TIMER_COMPARE: rdata_o = compare_q;
      default:        rdata_o = 32'h0;
    endcase
  end

  assign intr_o = en_q && (count_q >= compare_q);

endmodule

`default_nettype wire

/* src/peripheral_subsystem.sv */
// PLIC at 0x0000, GPIO at 0x1000, timer at 0x2000; 0x3000 is unmapped
// Interrupt sources are GPIO 1-8, timer 9 and external 10-13
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module peripheral_subsystem (
  input  wire logic                          clk_i,
  input  wire logic                          rst_i,
  input  wire logic                          slave_req_i,
  input  wire logic                          slave_we_i,
  input  wire logic [31:0]                   slave_addr_i,
  input  wire logic [31:0]                   slave_wdata_i,
  input  wire logic [3:0]                    slave_be_i,
  output logic                               slave_gnt_o,
  output logic                               slave_rvalid_o,
  output logic [31:0]                        slave_rdata_o,
  output logic                               slave_err_o,
  input  wire logic [`PERIPH_NUM_EXT_INT-1:0] intr_ext_i,
  output logic                               irq_plic_o,
  output logic                               msip_o,
  input  wire logic [`GPIO_WIDTH-1:0]        gpio_i,
  output logic [`GPIO_WIDTH-1:0]             gpio_o,
  output logic [`GPIO_WIDTH-1:0]             gpio_en_o,
  output logic                               timer_intr_o
);

  import periph_pkg::*;

  logic        reg_valid, reg_err;
  reg_op_e     reg_op, per_op;
  logic [31:0] reg_addr, reg_wdata, reg_rdata, per_wdata;
  logic [3:0]  reg_be, per_be, per_offset;
  logic        plic_valid, gpio_valid, tmr_valid;
  logic [31:0] plic_rdata, gpio_rdata, tmr_rdata;

  logic [`GPIO_WIDTH-1:0]  gpio_intr;
  logic [`PLIC_NUM_SRC-1:0] intr_src;

  assign intr_src[0] = 1'b0;
  assign intr_src[`PLIC_SRC_GPIO +: `GPIO_WIDTH] = gpio_intr;
  assign intr_src[`PLIC_SRC_TIMER] = timer_intr_o;
  assign intr_src[`PLIC_SRC_EXT +: `PERIPH_NUM_EXT_INT] = intr_ext_i;
  assign intr_src[`PLIC_NUM_SRC-1:`PLIC_SRC_EXT+`PERIPH_NUM_EXT_INT] = '0;

  obi_to_reg u_bridge (
    .clk_i, .rst_i,
    .req_i(slave_req_i), .we_i(slave_we_i), .addr_i(slave_addr_i),
    .wdata_i(slave_wdata_i), .be_i(slave_be_i),
    .gnt_o(slave_gnt_o), .rvalid_o(slave_rvalid_o),
    .rdata_o(slave_rdata_o), .err_o(slave_err_o),
    .reg_valid_o(reg_valid), .reg_op_o(reg_op), .reg_addr_o(reg_addr),
    .reg_wdata_o(reg_wdata), .reg_be_o(reg_be),
    .reg_rdata_i(reg_rdata), .reg_err_i(reg_err)
  );

  periph_reg_demux u_demux (
    .reg_valid_i(reg_valid), .reg_op_i(reg_op), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_be_i(reg_be),
    .reg_rdata_o(reg_rdata), .reg_err_o(reg_err),
    .plic_valid_o(plic_valid), .gpio_valid_o(gpio_valid), .tmr_valid_o(tmr_valid),
    .op_o(per_op), .offset_o(per_offset), .wdata_o(per_wdata), .be_o(per_be),
    .plic_rdata_i(plic_rdata), .gpio_rdata_i(gpio_rdata), .tmr_rdata_i(tmr_rdata)
  );

  intr_ctrl u_plic (
    .clk_i, .rst_i,
    .valid_i(plic_valid), .op_i(per_op), .offset_i(per_offset),
    .wdata_i(per_wdata), .be_i(per_be), .intr_src_i(intr_src),
    .rdata_o(plic_rdata), .irq_o(irq_plic_o), .msip_o
  );

  gpio_ctrl u_gpio (
    .clk_i, .rst_i,
    .valid_i(gpio_valid), .op_i(per_op), .offset_i(per_offset),
    .wdata_i(per_wdata), .be_i(per_be), .gpio_i,
    .rdata_o(gpio_rdata), .gpio_o, .gpio_en_o, .intr_o(gpio_intr)
  );

  event_timer u_timer (
    .clk_i, .rst_i,
    .valid_i(tmr_valid), .op_i(per_op), .offset_i(per_offset),
    .wdata_i(per_wdata), .be_i(per_be),
    .rdata_o(tmr_rdata), .intr_o(timer_intr_o)
  );

endmodule

`default_nettype wire

/* tests/periph_checker.sv */
// Shadows the plain registers and checks every bus response at rvalid
// Self-changing registers are checked only when the testbench posts a value
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module periph_checker (
  input  wire logic        clk_i,
  input  wire logic        rst_i,
  input  wire logic        req_i,
  input  wire logic        we_i,
  input  wire logic [31:0] addr_i,
  input  wire logic [31:0] wdata_i,
  input  wire logic [3:0]  be_i,
  input  wire logic        gnt_i,
  input  wire logic        rvalid_i,
  input  wire logic [31:0] rdata_i,
  input  wire logic        err_i,
  input  wire logic        irq_i,
  input  wire logic        msip_i,
  input  wire logic [7:0]  gpio_out_i,
  input  wire logic [7:0]  gpio_en_i,
  input  wire logic        timer_intr_i,
  input  wire logic        exp_valid_i,
  input  wire logic [31:0] exp_data_i,
  output int               errors_o
);

  string       test_name = "reset";
  logic [7:0]  sh_out, sh_dir, sh_ie;
  logic [15:0] sh_plic_en;
  logic        sh_msip, sh_tmr_en;
  logic [31:0] sh_cmp;
  logic        rsp_known, rsp_err, rst_q;
  logic [31:0] rsp_data;

  initial errors_o = 0;

  task automatic start_test(input string name);
    test_name = name;
  endtask

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    if (act !== exp) begin
      $display("Mismatch in %s, %s: expected %h, actual %h", test_name, what, exp, act);
      errors_o = errors_o + 1;
    end
  endtask

  function automatic logic [31:0] base_of(input logic [31:0] addr);
    logic [31:0] base;
    base = 32'h0;
    base[`PERIPH_SEL_BIT_HI:`PERIPH_SEL_BIT_LO] = addr[`PERIPH_SEL_BIT_HI:`PERIPH_SEL_BIT_LO];
    return base;
  endfunction

  // Expected read data; returns 0 where the value is not a plain register
  function automatic logic ref_read(input logic [31:0] addr, output logic [31:0] data,
                                    output logic err);
    logic [5:0] off;
    off = {addr[5:2], 2'b00};
    data = 32'h0;
    err = 1'b0;
    ref_read = 1'b1;
    case (base_of(addr))
      `PERIPH_BASE_PLIC: begin
        if (off == `PLIC_ENABLE) data = {16'h0, sh_plic_en};
        if (off == `PLIC_MSIP) data = {31'h0, sh_msip};
        if (off == `PLIC_PENDING || off == `PLIC_CLAIM) ref_read = 1'b0;
      end
      `PERIPH_BASE_GPIO: begin
        if (off == `GPIO_OUT) data = {24'h0, sh_out};
        if (off == `GPIO_DIR) data = {24'h0, sh_dir};
        if (off == `GPIO_INTR_EN) data = {24'h0, sh_ie};
        if (off == `GPIO_IN || off == `GPIO_INTR_STATUS) ref_read = 1'b0;
      end
      `PERIPH_BASE_TIMER: begin
        if (off == `TIMER_CTRL) data = {31'h0, sh_tmr_en};
        if (off == `TIMER_COMPARE) data = sh_cmp;
        if (off == `TIMER_COUNT) ref_read = 1'b0;
      end
      default: err = 1'b1;
    endcase
  endfunction

  task automatic shadow_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] be);
    logic [5:0] off;
    off = {addr[5:2], 2'b00};
    case (base_of(addr))
      `PERIPH_BASE_PLIC: begin
        for (int b = 0; b < 2; b++) begin
          if (off == `PLIC_ENABLE && be[b]) sh_plic_en[8*b +: 8] <= data[8*b +: 8];
        end
        if (off == `PLIC_MSIP && be[0]) sh_msip <= data[0];
      end
      `PERIPH_BASE_GPIO: begin
        if (off == `GPIO_OUT && be[0]) sh_out <= data[7:0];
        if (off == `GPIO_DIR && be[0]) sh_dir <= data[7:0];
        if (off == `GPIO_INTR_EN && be[0]) sh_ie <= data[7:0];
      end
      `PERIPH_BASE_TIMER: begin
        if (off == `TIMER_CTRL && be[0]) sh_tmr_en <= data[0];
        for (int b = 0; b < 4; b++) begin
          if (off == `TIMER_COMPARE && be[b]) sh_cmp[8*b +: 8] <= data[8*b +: 8];
        end
      end
      default: ;
    endcase
  endtask

  always @(posedge clk_i) begin
    logic [31:0] exp_data;
    logic        exp_err;
    logic        known;
    rst_q <= rst_i;
    if (rst_i) begin
      sh_out     <= 8'h0;
      sh_dir     <= 8'h0;
      sh_ie      <= 8'h0;
      sh_plic_en <= 16'h0;
      sh_msip    <= 1'b0;
      sh_tmr_en  <= 1'b0;
      sh_cmp     <= 32'h0;
      rsp_known  <= 1'b0;
    end else begin
      if (rst_q === 1'b1) begin
        compare_value("gnt after reset", 32'h1, 32'(gnt_i));
        compare_value("outputs after reset", 32'h0,
                      {12'h0, rvalid_i, irq_i, msip_i, timer_intr_i, gpio_out_i, gpio_en_i});
      end
      if (req_i && gnt_i) begin
        known = ref_read(addr_i, exp_data, exp_err);
        if (we_i) begin
          known    = 1'b1;
          exp_data = 32'h0;
          if (!exp_err) shadow_write(addr_i, wdata_i, be_i);
        end else if (exp_valid_i) begin
          known    = 1'b1;
          exp_data = exp_data_i;
        end
        rsp_known <= known;
        rsp_data  <= exp_data;
        rsp_err   <= exp_err;
      end
      if (rvalid_i) begin
        compare_value("err", 32'(rsp_err), 32'(err_i));
        if (rsp_known) compare_value("rdata", rsp_data, rdata_i);
        compare_value("gpio_o", 32'(sh_out), 32'(gpio_out_i));
        compare_value("gpio_en_o", 32'(sh_dir), 32'(gpio_en_i));
        compare_value("msip_o", 32'(sh_msip), 32'(msip_i));
        if ($isunknown({irq_i, timer_intr_i})) begin
          $display("Interrupt outputs are unknown during test %s", test_name);
          errors_o = errors_o + 1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* tests/tb_peripheral_subsystem.sv */
// Inputs change on falling edges; response checks run in periph_checker
// Each wait on the DUT gives up after a fixed number of cycles
`timescale 1ns/100ps
`default_nettype none

`include "periph_params.svh"

module tb_peripheral_subsystem;

  localparam logic [31:0] addr_plic_en     = `PERIPH_BASE_PLIC | 32'(`PLIC_ENABLE);
  localparam logic [31:0] addr_plic_claim  = `PERIPH_BASE_PLIC | 32'(`PLIC_CLAIM);
  localparam logic [31:0] addr_plic_msip   = `PERIPH_BASE_PLIC | 32'(`PLIC_MSIP);
  localparam logic [31:0] addr_gpio_out    = `PERIPH_BASE_GPIO | 32'(`GPIO_OUT);
  localparam logic [31:0] addr_gpio_dir    = `PERIPH_BASE_GPIO | 32'(`GPIO_DIR);
  localparam logic [31:0] addr_gpio_in     = `PERIPH_BASE_GPIO | 32'(`GPIO_IN);
  localparam logic [31:0] addr_gpio_ie     = `PERIPH_BASE_GPIO | 32'(`GPIO_INTR_EN);
  localparam logic [31:0] addr_gpio_status = `PERIPH_BASE_GPIO | 32'(`GPIO_INTR_STATUS);
  localparam logic [31:0] addr_tmr_ctrl    = `PERIPH_BASE_TIMER | 32'(`TIMER_CTRL);
  localparam logic [31:0] addr_tmr_count   = `PERIPH_BASE_TIMER | 32'(`TIMER_COUNT);
  localparam logic [31:0] addr_tmr_cmp     = `PERIPH_BASE_TIMER | 32'(`TIMER_COMPARE);
  localparam logic [31:0] addr_unmapped    = 32'h0000_3000;

  logic        clk, rst, req, we, exp_valid;
  logic [31:0] addr, wdata, exp_data;
  logic [3:0]  be, intr_ext;
  logic [7:0]  gpio_in;
  wire         gnt, rvalid, err, irq, msip, timer_intr;
  wire  [31:0] rdata;
  wire  [7:0]  gpio_out, gpio_en;
  int          chk_errors;
  int          tb_errors;
  int          seed;

  peripheral_subsystem u_dut (
    .clk_i(clk), .rst_i(rst),
    .slave_req_i(req), .slave_we_i(we), .slave_addr_i(addr),
    .slave_wdata_i(wdata), .slave_be_i(be),
    .slave_gnt_o(gnt), .slave_rvalid_o(rvalid), .slave_rdata_o(rdata), .slave_err_o(err),
    .intr_ext_i(intr_ext), .irq_plic_o(irq), .msip_o(msip),
    .gpio_i(gpio_in), .gpio_o(gpio_out), .gpio_en_o(gpio_en), .timer_intr_o(timer_intr)
  );

  periph_checker u_checker (
    .clk_i(clk), .rst_i(rst),
    .req_i(req), .we_i(we), .addr_i(addr), .wdata_i(wdata), .be_i(be),
    .gnt_i(gnt), .rvalid_i(rvalid), .rdata_i(rdata), .err_i(err),
    .irq_i(irq), .msip_i(msip), .gpio_out_i(gpio_out), .gpio_en_i(gpio_en),
    .timer_intr_i(timer_intr), .exp_valid_i(exp_valid), .exp_data_i(exp_data),
    .errors_o(chk_errors)
  );

  always #10 clk = ~clk;

  task automatic report_timeout(input string what);
    tb_errors++;
    $display("Timeout waiting for %s in test %s", what, u_checker.test_name);
  endtask

  task automatic bus_access(input logic is_write, input logic [31:0] a,
                            input logic [31:0] d, input logic [3:0] b,
                            output logic [31:0] rd);
    int cycles;
    rd = 32'h0;
    @(negedge clk);
    req   = 1'b1;
    we    = is_write;
    addr  = a;
    wdata = d;
    be    = b;
    cycles = 0;
    while (!gnt && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    if (!gnt) begin
      report_timeout("gnt");
      req = 1'b0;
    end else begin
      @(negedge clk);
      req = 1'b0;
      cycles = 0;
      while (!rvalid && cycles < 20) begin
        @(negedge clk);
        cycles++;
      end
      if (rvalid) rd = rdata;
      else report_timeout("rvalid");
    end
  endtask

  task automatic write_reg(input logic [31:0] a, input logic [31:0] d, input logic [3:0] b);
    logic [31:0] unused_rd;
    bus_access(1'b1, a, d, b, unused_rd);
  endtask

  task automatic read_reg(input logic [31:0] a, output logic [31:0] rd);
    bus_access(1'b0, a, 32'h0, 4'hF, rd);
  endtask

  // Posts the expected value of a register that the checker cannot shadow
  task automatic read_check(input logic [31:0] a, input logic [31:0] exp);
    logic [31:0] rd;
    exp_valid = 1'b1;
    exp_data  = exp;
    read_reg(a, rd);
    exp_valid = 1'b0;
  endtask

  task automatic wait_irq(input logic level, input int limit);
    int cycles;
    cycles = 0;
    while (irq !== level && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (irq !== level) report_timeout("irq_plic_o");
  endtask

  task automatic wait_timer_intr(input int limit);
    int cycles;
    cycles = 0;
    while (timer_intr !== 1'b1 && cycles < limit) begin
      @(negedge clk);
      cycles++;
    end
    if (timer_intr !== 1'b1) report_timeout("timer_intr_o");
  endtask

  // Claims until nothing is pending
  task automatic drain_claims();
    logic [31:0] rd;
    int n;
    n = 0;
    rd = 32'h1;
    while (rd != 32'h0 && n < `PLIC_NUM_SRC) begin
      read_reg(addr_plic_claim, rd);
      n++;
    end
  endtask

  function automatic logic [31:0] rw_reg_addr(input int idx);
    case (idx)
      0:       return addr_gpio_out;
      1:       return addr_gpio_dir;
      2:       return addr_plic_en;
      3:       return addr_tmr_cmp;
      default: return addr_tmr_ctrl;
    endcase
  endfunction

  initial begin
    logic [31:0] rd;
    logic [31:0] rnd;
    logic [31:0] cmp;
    logic [7:0]  pins;
    int          pick;
    seed      = 32'h755d_b44c;
    tb_errors = 0;
    clk       = 1'b0;
    rst       = 1'b1;
    req       = 1'b0;
    we        = 1'b0;
    addr      = 32'h0;
    wdata     = 32'h0;
    be        = 4'h0;
    intr_ext  = 4'h0;
    gpio_in   = 8'h0;
    exp_valid = 1'b0;
    exp_data  = 32'h0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    u_checker.start_test("reg_rw");
    for (int i = 0; i < 40; i++) begin
      pick = $unsigned($random(seed)) % 5;
      rnd  = $random(seed);
      write_reg(rw_reg_addr(pick), rnd, 4'($random(seed)));
      read_reg(rw_reg_addr(pick), rd);
    end
    // Random enables may have let the timer fire
    write_reg(addr_tmr_ctrl, 32'h0, 4'hF);
    write_reg(addr_plic_en, 32'hFFFF, 4'h3);
    drain_claims();

    u_checker.start_test("unmapped");
    rnd = $random(seed);
    write_reg(addr_unmapped, rnd, 4'hF);
    read_reg(addr_unmapped | 32'h4, rd);
    for (int i = 0; i < 5; i++) begin
      read_reg(rw_reg_addr(i), rd);
    end

    u_checker.start_test("gpio_intr");
    write_reg(addr_gpio_ie, 32'hFF, 4'h1);
    pins = 8'($random(seed));
    if (pins == 8'h0) pins = 8'h5A;
    @(negedge clk);
    gpio_in = pins;
    wait_irq(1'b1, 20);
    read_check(addr_gpio_in, 32'(pins));
    read_check(addr_gpio_status, 32'(pins));
    write_reg(addr_gpio_status, 32'(pins), 4'h1);
    read_check(addr_gpio_status, 32'h0);
    for (int i = 0; i < 8; i++) begin
      if (pins[i]) read_check(addr_plic_claim, `PLIC_SRC_GPIO + i);
    end
    read_check(addr_plic_claim, 32'h0);
    wait_irq(1'b0, 5);
    @(negedge clk);
    gpio_in = 8'h0;

    u_checker.start_test("ext_intr");
    @(negedge clk);
    intr_ext = 4'hF;
    wait_irq(1'b1, 10);
    intr_ext = 4'h0;
    for (int i = 0; i < `PERIPH_NUM_EXT_INT; i++) begin
      read_check(addr_plic_claim, `PLIC_SRC_EXT + i);
    end
    read_check(addr_plic_claim, 32'h0);

    u_checker.start_test("timer");
    write_reg(addr_tmr_ctrl, 32'h0, 4'h1);
    write_reg(addr_tmr_count, 32'h0, 4'hF);
    // Stopped timer holds the loaded count
    read_check(addr_tmr_count, 32'h0);
    cmp = 32'd20 + ($unsigned($random(seed)) % 32'd64);
    write_reg(addr_tmr_cmp, cmp, 4'hF);
    write_reg(addr_tmr_ctrl, 32'h1, 4'h1);
    wait_timer_intr(200);
    write_reg(addr_tmr_ctrl, 32'h0, 4'h1);
    wait_irq(1'b1, 5);
    read_check(addr_plic_claim, `PLIC_SRC_TIMER);
    read_check(addr_plic_claim, 32'h0);
    read_reg(addr_tmr_cmp, rd);

    u_checker.start_test("msip");
    write_reg(addr_plic_msip, 32'h1, 4'h1);
    read_reg(addr_plic_msip, rd);
    write_reg(addr_plic_msip, 32'h0, 4'hF);
    read_reg(addr_plic_msip, rd);
    // No byte enable, so no change
    write_reg(addr_plic_msip, 32'h1, 4'h0);
    read_reg(addr_plic_msip, rd);

    repeat (2) @(negedge clk);
    $display("Error count: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* project.f */
+incdir+src
src/periph_pkg.sv
src/obi_to_reg.sv
src/periph_reg_demux.sv
src/intr_ctrl.sv
src/gpio_ctrl.sv
src/event_timer.sv
src/peripheral_subsystem.sv
tests/periph_checker.sv
tests/tb_peripheral_subsystem.sv

/* Makefile */
# Verilator flow for the peripheral subsystem testbench
TOP = tb_peripheral_subsystem

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f project.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f project.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "^Regression passed$$" sim.log

clean:
	rm -rf obj_dir sim.log
